//--- common/frontend_settings.svh
`ifndef FRONTEND_SETTINGS_SVH
`define FRONTEND_SETTINGS_SVH

// Word width of the RV32I core
`define XLEN 32

// First fetch address after reset
`define RESET_PC 32'h0000_0000

// Byte address width on the memory port
`define MEM_AW 32

`endif

//--- common/rv_pkg.sv
package rv_pkg;

    ////////////////////////////////////////
    // RV32I major opcodes
    ////////////////////////////////////////
    typedef enum logic [6:0] {
        OP       = 7'b0110011,
        OP_IMM   = 7'b0010011,
        LOAD     = 7'b0000011,
        STORE    = 7'b0100011,
        BRANCH   = 7'b1100011,
        JAL      = 7'b1101111,
        JALR     = 7'b1100111,
        LUI      = 7'b0110111,
        AUIPC    = 7'b0010111,
        MISC_MEM = 7'b0001111,
        SYSTEM   = 7'b1110011
    } opcode_e;

    ////////////////////////////////////////
    // Immediate formats
    ////////////////////////////////////////
    typedef enum logic [2:0] {
        FMT_R   = 3'd0,  // No immediate
        FMT_I   = 3'd1,
        FMT_S   = 3'd2,
        FMT_B   = 3'd3,
        FMT_U   = 3'd4,
        FMT_J   = 3'd5,
        FMT_BAD = 3'd7   // Unknown opcode
    } imm_fmt_e;

    ////////////////////////////////////////
    // Memory arbiter grant
    ////////////////////////////////////////
    typedef enum logic [1:0] {
        GNT_IDLE  = 2'd0,
        GNT_FETCH = 2'd1,
        GNT_DATA  = 2'd2
    } grant_e;

endpackage

//--- logic/mem_arbiter.sv
`timescale 1ns/10ps
`include "frontend_settings.svh"

module mem_arbiter (
    input  logic               CLK,
    input  logic               rst,

    // Fetch requester, read only
    input  logic               fetch_req,
    input  logic [`MEM_AW-1:0] fetch_addr,
    output logic               fetch_done,
    output logic [`XLEN-1:0]   fetch_rdata,

    // Load/store side port
    input  logic               data_req,
    input  logic               data_we,
    input  logic [`MEM_AW-1:0] data_addr,
    input  logic [`XLEN-1:0]   data_wdata,
    output logic               data_done,
    output logic [`XLEN-1:0]   data_rdata,

    // Memory port
    output logic               mem_req,
    output logic               mem_we,
    output logic [`MEM_AW-1:0] mem_addr,
    output logic [`XLEN-1:0]   mem_wdata,
    input  logic               mem_ready,
    input  logic [`XLEN-1:0]   mem_rdata
);

    rv_pkg::grant_e state;

    ////////////////////////////////////////
    // Grant FSM
    ////////////////////////////////////////
    always_ff @(posedge CLK) begin
        if (rst) begin
            state <= rv_pkg::GNT_IDLE;
        end else begin
            case (state)
                rv_pkg::GNT_IDLE: begin
                    if (data_req)                   // Data side first
                        state <= rv_pkg::GNT_DATA;
                    else if (fetch_req)
                        state <= rv_pkg::GNT_FETCH;
                end
                rv_pkg::GNT_FETCH, rv_pkg::GNT_DATA: begin
                    if (mem_ready)
                        state <= rv_pkg::GNT_IDLE;
                end
                default: state <= rv_pkg::GNT_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////
    // Steering
    ////////////////////////////////////////
    assign mem_req   = (state != rv_pkg::GNT_IDLE);
    assign mem_we    = (state == rv_pkg::GNT_DATA) && data_we;
    assign mem_addr  = (state == rv_pkg::GNT_DATA) ? data_addr : fetch_addr;
    assign mem_wdata = data_wdata;

    assign fetch_done  = (state == rv_pkg::GNT_FETCH) && mem_ready;
    assign data_done   = (state == rv_pkg::GNT_DATA) && mem_ready;
    assign fetch_rdata = mem_rdata;
    assign data_rdata  = mem_rdata;

    // Grant is held for the whole access
    a_grant_hold: assert property (@(posedge CLK) disable iff (rst)
        (state != rv_pkg::GNT_IDLE && !mem_ready) |=> $stable(state))
        else $error("grant changed before mem_ready");

    a_fetch_read: assert property (@(posedge CLK) disable iff (rst)
        (state == rv_pkg::GNT_FETCH) |-> !mem_we)
        else $error("fetch access drove a write");

endmodule

//--- fetch/fetch_unit.sv
`timescale 1ns/10ps
`include "frontend_settings.svh"

module fetch_unit (
    input  logic             CLK,
    input  logic             rst,
    input  logic             stall,
    input  logic             flush,
    input  logic [`XLEN-1:0] flush_pc,

    // Toward the arbiter
    output logic             fetch_req,
    output logic [`XLEN-1:0] fetch_addr,
    input  logic             fetch_done,
    input  logic [`XLEN-1:0] fetch_rdata,

    // Toward decode
    output logic [`XLEN-1:0] inst_pc,
    output logic [`XLEN-1:0] inst_data,
    output logic             mem_wait
);

    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] req_addr;   // Address of the outstanding fetch
    logic             busy;
    logic             drop;       // Outstanding fetch predates a flush
    logic             held;
    logic [`XLEN-1:0] hold_data;
    logic             avail;
    logic             take;

    assign avail = held || (fetch_done && !drop);
    assign take  = avail && !stall;

    ////////////////////////////////////////
    // Request and PC
    ////////////////////////////////////////
    always_ff @(posedge CLK) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (busy) begin
            if (fetch_done)
                busy <= 1'b0;
        end else if (!held && !flush) begin
            busy     <= 1'b1;
            req_addr <= pc;
        end
    end

    always_ff @(posedge CLK) begin
        if (rst)
            pc <= `RESET_PC;
        else if (flush)
            pc <= flush_pc;
        else if (take)
            pc <= pc + 32'd4;
    end

    always_ff @(posedge CLK) begin
        if (rst)
            drop <= 1'b0;
        else if (flush && busy && !fetch_done)
            drop <= 1'b1;
        else if (fetch_done)
            drop <= 1'b0;   // Stale result consumed here
    end

    ////////////////////////////////////////
    // Hold buffer
    ////////////////////////////////////////
    always_ff @(posedge CLK) begin
        if (rst || flush) begin
            held <= 1'b0;
        end else if (held) begin
            if (!stall)
                held <= 1'b0;
        end else if (fetch_done && !drop && stall) begin
            held      <= 1'b1;
            hold_data <= fetch_rdata;
        end
    end

    assign fetch_req  = busy;
    assign fetch_addr = req_addr;
    assign inst_pc    = pc;
    assign inst_data  = held ? hold_data : fetch_rdata;
    assign mem_wait   = !take;

    // The arbiter relies on a stable request
    a_req_stable: assert property (@(posedge CLK) disable iff (rst)
        (fetch_req && !fetch_done) |=> (fetch_req && $stable(fetch_addr)))
        else $error("fetch request dropped or moved in flight");

endmodule

//--- decode/decode_1st.sv
`timescale 1ns/10ps
`include "frontend_settings.svh"

module decode_1st (
    input  logic               CLK,
    input  logic               rst,
    input  logic               flush,
    input  logic               stall,
    input  logic               mem_wait,

    // From fetch
    input  logic [`XLEN-1:0]   inst_pc,
    input  logic [`XLEN-1:0]   inst_data,

    // To decode_2nd
    output logic [`XLEN-1:0]   decode_1st_pc,
    output rv_pkg::opcode_e    decode_1st_opcode,
    output logic [4:0]         decode_1st_rd,
    output logic [4:0]         decode_1st_rs1,
    output logic [4:0]         decode_1st_rs2,
    output logic [2:0]         decode_1st_funct3,
    output logic [6:0]         decode_1st_funct7,
    output logic [`XLEN-1:0]   decode_1st_imm,
    output rv_pkg::imm_fmt_e   decode_1st_fmt
);

    logic [`XLEN-1:0] pc_q;
    logic [`XLEN-1:0] inst_q;

    always_ff @(posedge CLK) begin
        if (rst || flush) begin
            pc_q   <= '0;
            inst_q <= '0;   // Bubble
        end else if (!stall && !mem_wait) begin
            pc_q   <= inst_pc;
            inst_q <= inst_data;
        end
    end

    ////////////////////////////////////////
    // Field split
    ////////////////////////////////////////
    assign decode_1st_pc     = pc_q;
    assign decode_1st_opcode = rv_pkg::opcode_e'(inst_q[6:0]);
    assign decode_1st_rd     = inst_q[11:7];
    assign decode_1st_rs1    = inst_q[19:15];
    assign decode_1st_rs2    = inst_q[24:20];
    assign decode_1st_funct3 = inst_q[14:12];
    assign decode_1st_funct7 = inst_q[31:25];

    always_comb begin
        case (decode_1st_opcode)
            rv_pkg::OP:                  decode_1st_fmt = rv_pkg::FMT_R;
            rv_pkg::OP_IMM, rv_pkg::LOAD, rv_pkg::JALR,
            rv_pkg::MISC_MEM, rv_pkg::SYSTEM:
                                         decode_1st_fmt = rv_pkg::FMT_I;
            rv_pkg::STORE:               decode_1st_fmt = rv_pkg::FMT_S;
            rv_pkg::BRANCH:              decode_1st_fmt = rv_pkg::FMT_B;
            rv_pkg::LUI, rv_pkg::AUIPC:  decode_1st_fmt = rv_pkg::FMT_U;
            rv_pkg::JAL:                 decode_1st_fmt = rv_pkg::FMT_J;
            default:                     decode_1st_fmt = rv_pkg::FMT_BAD;
        endcase
    end

    // Immediate still zero extended here
    always_comb begin
        case (decode_1st_fmt)
            rv_pkg::FMT_R: decode_1st_imm = '0;
            rv_pkg::FMT_I: decode_1st_imm = {20'b0, inst_q[31:20]};
            rv_pkg::FMT_S: decode_1st_imm = {20'b0, inst_q[31:25], inst_q[11:7]};
            rv_pkg::FMT_B: decode_1st_imm = {19'b0, inst_q[31], inst_q[7],
                                             inst_q[30:25], inst_q[11:8], 1'b0};
            rv_pkg::FMT_U: decode_1st_imm = {inst_q[31:12], 12'b0};
            rv_pkg::FMT_J: decode_1st_imm = {11'b0, inst_q[31], inst_q[19:12],
                                             inst_q[20], inst_q[30:21], 1'b0};
            default:       decode_1st_imm = '1;
        endcase
    end

endmodule

//--- decode/decode_2nd.sv
`timescale 1ns/10ps
`include "frontend_settings.svh"

module decode_2nd (
    input  logic               CLK,
    input  logic               rst,
    input  logic               flush,
    input  logic               stall,
    input  logic               mem_wait,

    // From decode_1st
    input  logic [`XLEN-1:0]   decode_1st_pc,
    input  rv_pkg::opcode_e    decode_1st_opcode,
    input  logic [4:0]         decode_1st_rd,
    input  logic [4:0]         decode_1st_rs1,
    input  logic [4:0]         decode_1st_rs2,
    input  logic [2:0]         decode_1st_funct3,
    input  logic [6:0]         decode_1st_funct7,
    input  logic [`XLEN-1:0]   decode_1st_imm,
    input  rv_pkg::imm_fmt_e   decode_1st_fmt,

    // Decoded instruction
    output logic [`XLEN-1:0]   dec_pc,
    output rv_pkg::opcode_e    dec_opcode,
    output logic [4:0]         dec_rd,
    output logic [4:0]         dec_rs1,
    output logic [4:0]         dec_rs2,
    output logic [2:0]         dec_funct3,
    output logic [6:0]         dec_funct7,
    output logic [`XLEN-1:0]   dec_imm,
    output rv_pkg::imm_fmt_e   dec_fmt,
    output logic               dec_illegal
);

    function automatic logic [`XLEN-1:0] sext_imm(input logic [`XLEN-1:0] imm,
                                                  input rv_pkg::imm_fmt_e fmt);
        case (fmt)
            rv_pkg::FMT_I, rv_pkg::FMT_S: sext_imm = {{20{imm[11]}}, imm[11:0]};
            rv_pkg::FMT_B:                sext_imm = {{19{imm[12]}}, imm[12:0]};
            rv_pkg::FMT_J:                sext_imm = {{11{imm[20]}}, imm[20:0]};
            default:                      sext_imm = imm;   // U, R and BAD as is
        endcase
    endfunction

    ////////////////////////////////////////
    // Stage register
    ////////////////////////////////////////
    always_ff @(posedge CLK) begin
        if (rst || flush) begin
            // Same view as an all-zero instruction
            dec_pc      <= '0;
            dec_opcode  <= rv_pkg::opcode_e'(7'd0);
            dec_rd      <= '0;
            dec_rs1     <= '0;
            dec_rs2     <= '0;
            dec_funct3  <= '0;
            dec_funct7  <= '0;
            dec_imm     <= '1;
            dec_fmt     <= rv_pkg::FMT_BAD;
            dec_illegal <= 1'b1;
        end else if (!stall && !mem_wait) begin
            dec_pc      <= decode_1st_pc;
            dec_opcode  <= decode_1st_opcode;
            dec_rd      <= decode_1st_rd;
            dec_rs1     <= decode_1st_rs1;
            dec_rs2     <= decode_1st_rs2;
            dec_funct3  <= decode_1st_funct3;
            dec_funct7  <= decode_1st_funct7;
            dec_imm     <= sext_imm(decode_1st_imm, decode_1st_fmt);
            dec_fmt     <= decode_1st_fmt;
            dec_illegal <= (decode_1st_fmt == rv_pkg::FMT_BAD);
        end
    end

endmodule

//--- logic/frontend_top.sv
`timescale 1ns/10ps
`include "frontend_settings.svh"

module frontend_top (
    input  logic               CLK,
    input  logic               rst,
    input  logic               stall,
    input  logic               flush,
    input  logic [`XLEN-1:0]   flush_pc,

    // Load/store side port
    input  logic               data_req,
    input  logic               data_we,
    input  logic [`MEM_AW-1:0] data_addr,
    input  logic [`XLEN-1:0]   data_wdata,
    output logic               data_done,
    output logic [`XLEN-1:0]   data_rdata,

    // Memory port
    output logic               mem_req,
    output logic               mem_we,
    output logic [`MEM_AW-1:0] mem_addr,
    output logic [`XLEN-1:0]   mem_wdata,
    input  logic               mem_ready,
    input  logic [`XLEN-1:0]   mem_rdata,

    // Decoded instruction
    output logic [`XLEN-1:0]   dec_pc,
    output rv_pkg::opcode_e    dec_opcode,
    output logic [4:0]         dec_rd,
    output logic [4:0]         dec_rs1,
    output logic [4:0]         dec_rs2,
    output logic [2:0]         dec_funct3,
    output logic [6:0]         dec_funct7,
    output logic [`XLEN-1:0]   dec_imm,
    output rv_pkg::imm_fmt_e   dec_fmt,
    output logic               dec_illegal
);

    logic               fetch_req;
    logic [`MEM_AW-1:0] fetch_addr;
    logic               fetch_done;
    logic [`XLEN-1:0]   fetch_rdata;
    logic [`XLEN-1:0]   inst_pc;
    logic [`XLEN-1:0]   inst_data;
    logic               mem_wait;

    logic [`XLEN-1:0]   d1_pc;
    rv_pkg::opcode_e    d1_opcode;
    logic [4:0]         d1_rd;
    logic [4:0]         d1_rs1;
    logic [4:0]         d1_rs2;
    logic [2:0]         d1_funct3;
    logic [6:0]         d1_funct7;
    logic [`XLEN-1:0]   d1_imm;
    rv_pkg::imm_fmt_e   d1_fmt;

    ////////////////////////////////////////
    // Fetch and memory
    ////////////////////////////////////////
    fetch_unit u_fetch (
        .CLK(CLK), .rst(rst), .stall(stall), .flush(flush), .flush_pc(flush_pc),
        .fetch_req(fetch_req), .fetch_addr(fetch_addr),
        .fetch_done(fetch_done), .fetch_rdata(fetch_rdata),
        .inst_pc(inst_pc), .inst_data(inst_data), .mem_wait(mem_wait)
    );

    mem_arbiter u_arb (
        .CLK(CLK), .rst(rst),
        .fetch_req(fetch_req), .fetch_addr(fetch_addr),
        .fetch_done(fetch_done), .fetch_rdata(fetch_rdata),
        .data_req(data_req), .data_we(data_we), .data_addr(data_addr),
        .data_wdata(data_wdata), .data_done(data_done), .data_rdata(data_rdata),
        .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_ready(mem_ready), .mem_rdata(mem_rdata)
    );

    ////////////////////////////////////////
    // Decode
    ////////////////////////////////////////
    decode_1st u_dec1 (
        .CLK(CLK), .rst(rst), .flush(flush), .stall(stall), .mem_wait(mem_wait),
        .inst_pc(inst_pc), .inst_data(inst_data),
        .decode_1st_pc(d1_pc), .decode_1st_opcode(d1_opcode),
        .decode_1st_rd(d1_rd), .decode_1st_rs1(d1_rs1), .decode_1st_rs2(d1_rs2),
        .decode_1st_funct3(d1_funct3), .decode_1st_funct7(d1_funct7),
        .decode_1st_imm(d1_imm), .decode_1st_fmt(d1_fmt)
    );

    decode_2nd u_dec2 (
        .CLK(CLK), .rst(rst), .flush(flush), .stall(stall), .mem_wait(mem_wait),
        .decode_1st_pc(d1_pc), .decode_1st_opcode(d1_opcode),
        .decode_1st_rd(d1_rd), .decode_1st_rs1(d1_rs1), .decode_1st_rs2(d1_rs2),
        .decode_1st_funct3(d1_funct3), .decode_1st_funct7(d1_funct7),
        .decode_1st_imm(d1_imm), .decode_1st_fmt(d1_fmt),
        .dec_pc(dec_pc), .dec_opcode(dec_opcode), .dec_rd(dec_rd),
        .dec_rs1(dec_rs1), .dec_rs2(dec_rs2), .dec_funct3(dec_funct3),
        .dec_funct7(dec_funct7), .dec_imm(dec_imm), .dec_fmt(dec_fmt),
        .dec_illegal(dec_illegal)
    );

endmodule

//--- dv/tb_mem_model.sv
`timescale 1ns/10ps
`include "frontend_settings.svh"

module tb_mem_model (
    input  logic               CLK,
    input  logic               rst,
    input  logic               mem_req,
    input  logic               mem_we,
    input  logic [`MEM_AW-1:0] mem_addr,
    input  logic [`XLEN-1:0]   mem_wdata,
    output logic               mem_ready,
    output logic [`XLEN-1:0]   mem_rdata
);

    logic [`XLEN-1:0] words [0:4095];     // 16 KB, wraps on the word index
    logic [1:0]       delay_tab [0:255];  // Response delays, filled by the testbench
    logic [7:0]       delay_ptr;
    logic [1:0]       cnt;
    logic             active;

    always @(posedge CLK) begin
        if (rst) begin
            mem_ready <= 1'b0;
            mem_rdata <= '0;
            active    <= 1'b0;
            delay_ptr <= '0;
        end else if (mem_ready) begin
            mem_ready <= 1'b0;  // Arbiter returns to idle on this edge
            active    <= 1'b0;
        end else if (active) begin
            if (cnt == 2'd1) begin
                mem_ready <= 1'b1;
                mem_rdata <= words[mem_addr[13:2]];
                if (mem_we)
                    words[mem_addr[13:2]] <= mem_wdata;
            end else begin
                cnt <= cnt - 2'd1;
            end
        end else if (mem_req) begin
            active    <= 1'b1;
            cnt       <= delay_tab[delay_ptr];
            delay_ptr <= delay_ptr + 8'd1;
        end
    end

endmodule

//--- dv/frontend_tb.sv
`timescale 1ns/10ps
`include "frontend_settings.svh"

module frontend_tb;

    localparam int TIMEOUT = 100;

    logic               CLK;
    logic               rst;
    logic               stall;
    logic               flush;
    logic [`XLEN-1:0]   flush_pc;
    logic               data_req;
    logic               data_we;
    logic [`MEM_AW-1:0] data_addr;
    logic [`XLEN-1:0]   data_wdata;
    logic               data_done;
    logic [`XLEN-1:0]   data_rdata;
    logic               mem_req;
    logic               mem_we;
    logic [`MEM_AW-1:0] mem_addr;
    logic [`XLEN-1:0]   mem_wdata;
    logic               mem_ready;
    logic [`XLEN-1:0]   mem_rdata;
    logic [`XLEN-1:0]   dec_pc;
    rv_pkg::opcode_e    dec_opcode;
    logic [4:0]         dec_rd;
    logic [4:0]         dec_rs1;
    logic [4:0]         dec_rs2;
    logic [2:0]         dec_funct3;
    logic [6:0]         dec_funct7;
    logic [`XLEN-1:0]   dec_imm;
    rv_pkg::imm_fmt_e   dec_fmt;
    logic               dec_illegal;

    logic [`XLEN-1:0]   dec_q[$];      // Decoded PCs in arrival order
    logic [`XLEN-1:0]   prev_pc;
    logic               prev_ill;
    logic [`XLEN-1:0]   exp_pc;

    frontend_top DUT (.*);

    tb_mem_model u_mem (
        .CLK(CLK), .rst(rst), .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_ready(mem_ready), .mem_rdata(mem_rdata)
    );

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    ////////////////////////////////////////
    // Instruction encoders
    ////////////////////////////////////////
    function automatic logic [31:0] enc_r(input logic [4:0] rd, input logic [2:0] f3,
                                          input logic [4:0] rs1, input logic [4:0] rs2,
                                          input logic [6:0] f7);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [6:0] op, input logic [4:0] rd,
                                          input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_u(input logic [6:0] op, input logic [4:0] rd,
                                          input logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // Background ADDI whose immediate is the word index
    function automatic logic [31:0] fill_word(input int idx);
        logic [11:0] i;
        i = idx[11:0];
        return {i, i[4:0], 3'b000, i[9:5], 7'b0010011};
    endfunction

    ////////////////////////////////////////
    // Reference decoder
    ////////////////////////////////////////
    function automatic rv_pkg::imm_fmt_e ref_fmt(input logic [31:0] w);
        case (w[6:0])
            rv_pkg::OP:                           return rv_pkg::FMT_R;
            rv_pkg::OP_IMM, rv_pkg::LOAD, rv_pkg::JALR,
            rv_pkg::MISC_MEM, rv_pkg::SYSTEM:     return rv_pkg::FMT_I;
            rv_pkg::STORE:                        return rv_pkg::FMT_S;
            rv_pkg::BRANCH:                       return rv_pkg::FMT_B;
            rv_pkg::LUI, rv_pkg::AUIPC:           return rv_pkg::FMT_U;
            rv_pkg::JAL:                          return rv_pkg::FMT_J;
            default:                              return rv_pkg::FMT_BAD;
        endcase
    endfunction

    function automatic logic [31:0] ref_imm(input logic [31:0] w);
        case (ref_fmt(w))
            rv_pkg::FMT_R: return 32'd0;
            rv_pkg::FMT_I: return {{20{w[31]}}, w[31:20]};
            rv_pkg::FMT_S: return {{20{w[31]}}, w[31:25], w[11:7]};
            rv_pkg::FMT_B: return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            rv_pkg::FMT_U: return {w[31:12], 12'd0};
            rv_pkg::FMT_J: return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            default:       return 32'hFFFF_FFFF;
        endcase
    endfunction

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////
    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp)
            report_fail($sformatf("mismatch at %0t: %s got %h expected %h",
                                  $time, name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            report_fail($sformatf("mismatch at %0t: %s got %b expected %b",
                                  $time, name, got, exp));
    endtask

    task automatic check_opcode(input string name, input rv_pkg::opcode_e got,
                                input rv_pkg::opcode_e exp);
        if (got !== exp)
            report_fail($sformatf("mismatch at %0t: %s got %h expected %h",
                                  $time, name, got, exp));
    endtask

    task automatic check_fmt(input string name, input rv_pkg::imm_fmt_e got,
                             input rv_pkg::imm_fmt_e exp);
        if (got !== exp)
            report_fail($sformatf("mismatch at %0t: %s got %0d expected %0d",
                                  $time, name, got, exp));
    endtask

    // Compare the DUT outputs with the word stored at dec_pc
    task automatic check_decoded;
        logic [31:0] w;
        w = u_mem.words[dec_pc[13:2]];
        check_opcode("dec_opcode", dec_opcode, rv_pkg::opcode_e'(w[6:0]));
        check_word("dec_rd", 32'(dec_rd), 32'(w[11:7]));
        check_word("dec_rs1", 32'(dec_rs1), 32'(w[19:15]));
        check_word("dec_rs2", 32'(dec_rs2), 32'(w[24:20]));
        check_word("dec_funct3", 32'(dec_funct3), 32'(w[14:12]));
        check_word("dec_funct7", 32'(dec_funct7), 32'(w[31:25]));
        check_fmt("dec_fmt", dec_fmt, ref_fmt(w));
        check_word("dec_imm", dec_imm, ref_imm(w));
        check_bit("dec_illegal", dec_illegal, ref_fmt(w) == rv_pkg::FMT_BAD);
    endtask

    ////////////////////////////////////////
    // Cycle step and waits
    ////////////////////////////////////////
    task automatic tick;
        @(posedge CLK);
        #2;
        if (!rst && (dec_pc != prev_pc || dec_illegal != prev_ill)) begin
            if (!(dec_pc == '0 && dec_illegal)) begin   // Skip bubbles
                check_decoded();
                dec_q.push_back(dec_pc);
            end
        end
        prev_pc  = dec_pc;
        prev_ill = dec_illegal;
    endtask

    task automatic expect_next;
        int n;
        n = 0;
        while (dec_q.size() == 0) begin
            if (n >= TIMEOUT)
                report_fail($sformatf("Timeout waiting for a decoded instruction at %h",
                                      exp_pc));
            tick();
            n++;
        end
        check_word("dec_pc", dec_q.pop_front(), exp_pc);
        exp_pc = exp_pc + 32'd4;
    endtask

    task automatic flush_to(input logic [31:0] target);
        flush    = 1'b1;
        flush_pc = target;
        dec_q.delete();
        tick();
        flush  = 1'b0;
        exp_pc = target;
    endtask

    task automatic data_access(input logic we, input logic [31:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata);
        int  n;
        logic done;
        n = 0;
        done = 1'b0;
        data_req   = 1'b1;
        data_we    = we;
        data_addr  = addr;
        data_wdata = wdata;
        while (!done) begin
            if (n >= TIMEOUT)
                report_fail("Timeout waiting for data_done on the data port");
            tick();
            n++;
            if (data_done) begin
                done  = 1'b1;
                rdata = data_rdata;
            end
        end
        data_req = 1'b0;
        data_we  = 1'b0;
    endtask

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////
    task automatic test_reset;
        check_word("dec_pc", dec_pc, 32'd0);
        check_fmt("dec_fmt", dec_fmt, rv_pkg::FMT_BAD);
        check_bit("dec_illegal", dec_illegal, 1'b1);
        exp_pc = `RESET_PC;
        expect_next();
    endtask

    task automatic test_program;
        expect_next();
        check_word("dec_imm", dec_imm, 32'hFFFF_FFFD);  // addi -3
        repeat (8) expect_next();
    endtask

    task automatic test_illegal;
        expect_next();
        check_bit("dec_illegal", dec_illegal, 1'b1);
        check_word("dec_imm", dec_imm, 32'hFFFF_FFFF);
        expect_next();
        expect_next();
    endtask

    task automatic test_stall;
        logic [31:0]      pc_s;
        logic [31:0]      imm_s;
        rv_pkg::opcode_e  op_s;
        rv_pkg::imm_fmt_e fmt_s;
        logic             ill_s;
        logic [4:0]       rd_s;
        logic [4:0]       rs1_s;
        logic [4:0]       rs2_s;
        logic [2:0]       f3_s;
        logic [6:0]       f7_s;
        stall = 1'b1;
        pc_s  = dec_pc;
        imm_s = dec_imm;
        op_s  = dec_opcode;
        fmt_s = dec_fmt;
        ill_s = dec_illegal;
        rd_s  = dec_rd;
        rs1_s = dec_rs1;
        rs2_s = dec_rs2;
        f3_s  = dec_funct3;
        f7_s  = dec_funct7;
        repeat (12) begin
            tick();
            check_word("dec_pc", dec_pc, pc_s);
            check_word("dec_imm", dec_imm, imm_s);
            check_opcode("dec_opcode", dec_opcode, op_s);
            check_fmt("dec_fmt", dec_fmt, fmt_s);
            check_bit("dec_illegal", dec_illegal, ill_s);
            check_word("dec_rd", 32'(dec_rd), 32'(rd_s));
            check_word("dec_rs1", 32'(dec_rs1), 32'(rs1_s));
            check_word("dec_rs2", 32'(dec_rs2), 32'(rs2_s));
            check_word("dec_funct3", 32'(dec_funct3), 32'(f3_s));
            check_word("dec_funct7", 32'(dec_funct7), 32'(f7_s));
        end
        stall = 1'b0;
        repeat (4) expect_next();
    endtask

    task automatic test_flush;
        int n;
        n = 0;
        while (!(mem_req && !mem_we)) begin     // Catch a fetch in flight
            if (n >= TIMEOUT)
                report_fail("Timeout waiting for a fetch on the memory port");
            tick();
            n++;
        end
        flush_to(32'h0000_0400);
        repeat (3) expect_next();
    endtask

    task automatic test_data_port;
        logic [31:0] word;
        logic [31:0] rd;
        word = enc_u(rv_pkg::LUI, 5'd5, 20'hABCDE);
        data_access(1'b1, 32'h0000_0800, word, rd);
        data_access(1'b0, 32'h0000_0800, 32'd0, rd);
        check_word("data_rdata", rd, word);
        flush_to(32'h0000_0800);
        expect_next();
        check_opcode("dec_opcode", dec_opcode, rv_pkg::LUI);
        check_word("dec_imm", dec_imm, 32'hABCD_E000);
        check_word("dec_rd", 32'(dec_rd), 32'd5);
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////
    initial begin
        prev_pc    = '0;
        prev_ill   = 1'b1;
        exp_pc     = `RESET_PC;
        rst        = 1'b1;
        stall      = 1'b0;
        flush      = 1'b0;
        flush_pc   = '0;
        data_req   = 1'b0;
        data_we    = 1'b0;
        data_addr  = '0;
        data_wdata = '0;

        void'($urandom(32'he946c00f));
        for (int i = 0; i < 256; i++)
            u_mem.delay_tab[i] = 2'(1 + ($urandom % 3));
        for (int i = 0; i < 4096; i++)
            u_mem.words[i] = fill_word(i);
        u_mem.words[0]  = enc_i(rv_pkg::OP_IMM, 5'd1, 3'd0, 5'd0, 12'd5);
        u_mem.words[1]  = enc_i(rv_pkg::OP_IMM, 5'd2, 3'd0, 5'd1, -12'sd3);
        u_mem.words[2]  = enc_r(5'd3, 3'd0, 5'd1, 5'd2, 7'h20);
        u_mem.words[3]  = enc_s(3'd2, 5'd2, 5'd3, -12'sd8);
        u_mem.words[4]  = enc_b(3'd1, 5'd1, 5'd2, -13'sd16);
        u_mem.words[5]  = enc_u(rv_pkg::LUI, 5'd4, 20'h80000);
        u_mem.words[6]  = enc_j(5'd5, -21'sd2048);
        u_mem.words[7]  = enc_i(rv_pkg::LOAD, 5'd6, 3'd2, 5'd2, 12'h7F0);
        u_mem.words[8]  = enc_u(rv_pkg::AUIPC, 5'd7, 20'h00012);
        u_mem.words[9]  = enc_b(3'd0, 5'd3, 5'd4, 13'd100);
        u_mem.words[10] = 32'h1234_5677;    // Opcode 0x77 is not RV32I

        repeat (2) tick();
        rst = 1'b0;

        test_reset();
        test_program();
        test_illegal();
        test_stall();
        test_flush();
        test_data_port();

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- frontend_top.f
+incdir+common
common/rv_pkg.sv
logic/mem_arbiter.sv
fetch/fetch_unit.sv
decode/decode_1st.sv
decode/decode_2nd.sv
logic/frontend_top.sv
dv/tb_mem_model.sv
dv/frontend_tb.sv

//--- Bender.yml
package:
  name: frontend_top

sources:
  - include_dirs:
      - common
    files:
      - common/rv_pkg.sv
      - logic/mem_arbiter.sv
      - fetch/fetch_unit.sv
      - decode/decode_1st.sv
      - decode/decode_2nd.sv
      - logic/frontend_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - dv/tb_mem_model.sv
      - dv/frontend_tb.sv
